/* src/hash_map_macros.svh */
// Fixed sizes, CRC polynomial and node field positions of the hash map, included by RTL and test
`ifndef HASH_MAP_MACROS_SVH
`define HASH_MAP_MACROS_SVH

`define KEY_BITS        32
`define DAT_BITS        8
`define HASH_BITS       3
`define CHAIN_BITS      3
`define NODE_ADDR_BITS  4
`define CRC_POLY        32'h04C11DB7
`define NODE_BITS       44

// Bucket heads fill the lower half of the store, chain slots the upper half
`define NUM_BUCKETS     8
`define CHAIN_SLOTS     7
`define NUM_NODES       16

// Node layout, used flag on top and next pointer at the bottom
`define NODE_USED       43
`define NODE_KEY_HI     42
`define NODE_KEY_LO     11
`define NODE_DAT_HI     10
`define NODE_DAT_LO     3
`define NODE_NXT_HI     2
`define NODE_NXT_LO     0

`endif

/* src/hash_map_pkg.sv */
// Shared types of the hash map design, imported by every RTL block and the testbench
`include "hash_map_macros.svh"
`default_nettype none

package hash_map_pkg;

  typedef logic [`KEY_BITS-1:0]       key_t;
  typedef logic [`DAT_BITS-1:0]       dat_t;
  typedef logic [`HASH_BITS-1:0]      bucket_t;
  typedef logic [`CHAIN_BITS-1:0]     chain_ptr_t;
  typedef logic [`NODE_ADDR_BITS-1:0] node_addr_t;
  typedef logic [`NODE_BITS-1:0]      node_t;

  // Bucket walker FSM
  typedef enum logic [2:0] {
    IDLE,
    READ_BUCKET,
    READ_CHAIN,
    WRITE,
    DONE
  } walk_state_t;

  typedef enum logic [0:0] {
    LOOKUP = 1'b0,
    ADD    = 1'b1
  } opcode_t;

endpackage

`default_nettype wire

/* src/node_mem_if.sv */
// Port of one requester into the shared node store, requester side and store side
`timescale 1ns/1ps
`default_nettype none

interface node_mem_if;
  import hash_map_pkg::*;

  logic       req;
  logic       we;
  node_addr_t addr;
  node_t      wdata;
  // Combinational grant from the store arbiter
  logic       gnt;
  // Valid one cycle after a granted read
  node_t      rdata;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata
  );

  modport store (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

`default_nettype wire

/* src/crc_hash.sv */
// Combinational CRC-32 of a key, whose low bits select the bucket slot
`timescale 1ns/1ps
`include "hash_map_macros.svh"
`default_nettype none

module crc_hash (
  input  hash_map_pkg::key_t    i_key,
  output hash_map_pkg::bucket_t o_bucket
);
  import hash_map_pkg::*;

  logic [31:0] crc_val;

  // Zero seed, MSB first, no reflection and no final XOR
  function automatic logic [31:0] crc32(input key_t key);
    logic [31:0] crc;
    logic        fb;
    crc = '0;
    for (int i = `KEY_BITS - 1; i >= 0; i--) begin
      fb  = crc[31] ^ key[i];
      crc = {crc[30:0], 1'b0};
      if (fb) begin
        crc = crc ^ `CRC_POLY;
      end
    end
    return crc;
  endfunction

  assign crc_val  = crc32(i_key);
  assign o_bucket = crc_val[`HASH_BITS-1:0];

endmodule

`default_nettype wire

/* src/bucket_walker.sv */
// Request FSM of the hash map, walks bucket chains for lookups and adds and allocates chain nodes
`timescale 1ns/1ps
`include "hash_map_macros.svh"
`default_nettype none

module bucket_walker (
  input  logic                  i_clk,
  input  logic                  coll_ram_rst,
  input  hash_map_pkg::key_t    i_key,
  input  hash_map_pkg::dat_t    i_dat,
  input  logic                  i_val,
  input  logic                  i_opcode,
  input  logic                  i_clear_busy,
  input  hash_map_pkg::bucket_t i_bucket,
  output hash_map_pkg::key_t    o_key,
  output logic                  o_rdy,
  output hash_map_pkg::dat_t    o_dat,
  output logic                  o_val,
  output logic                  o_fnd,
  output logic                  o_full,
  node_mem_if.requester         mem
);
  import hash_map_pkg::*;

  walk_state_t state;
  key_t        key_q;
  dat_t        dat_q;
  opcode_t     op_q;
  dat_t        res_dat;
  logic        rdy_q;
  logic        rd_wait;
  logic        fnd_q;
  logic        full_q;
  logic        link_pend;
  chain_ptr_t  alloc_ptr;
  node_addr_t  cur_addr;
  node_addr_t  rd_addr;
  node_addr_t  wr_addr;
  node_addr_t  link_addr;
  node_t       rd_node;
  node_t       new_node;
  node_t       wr_node;
  node_t       link_node;
  logic        key_hit;

  assign rd_node  = mem.rdata;
  assign new_node = {1'b1, key_q, dat_q, {`CHAIN_BITS{1'b0}}};
  assign key_hit  = rd_node[`NODE_USED] && (rd_node[`NODE_KEY_HI:`NODE_KEY_LO] == key_q);
  // Bucket head comes straight from the hash, chain nodes from the last next pointer
  assign rd_addr  = (state == READ_BUCKET) ? {1'b0, i_bucket} : cur_addr;

  assign mem.req   = (((state == READ_BUCKET) || (state == READ_CHAIN)) && !rd_wait) ||
                     (state == WRITE);
  assign mem.we    = (state == WRITE);
  assign mem.addr  = (state == WRITE) ? wr_addr : rd_addr;
  assign mem.wdata = wr_node;

  assign o_key  = key_q;
  assign o_rdy  = rdy_q && !i_clear_busy;
  assign o_val  = (state == DONE) && !i_clear_busy;
  assign o_fnd  = o_val && fnd_q;
  assign o_dat  = res_dat;
  assign o_full = full_q && !i_clear_busy;

  always_ff @(posedge i_clk) begin
    if (!coll_ram_rst) begin
      state     <= IDLE;
      rdy_q     <= 1'b0;
      rd_wait   <= 1'b0;
      full_q    <= 1'b0;
      link_pend <= 1'b0;
      alloc_ptr <= chain_ptr_t'(1);
    end else begin
      case (state)
        IDLE: begin
          rdy_q <= 1'b1;
          key_q <= i_key;
          dat_q <= i_dat;
          op_q  <= opcode_t'(i_opcode);
          if (o_rdy && i_val) begin
            rdy_q <= 1'b0;
            state <= READ_BUCKET;
          end
        end
        READ_BUCKET, READ_CHAIN: begin
          if (!rd_wait) begin
            rd_wait <= mem.gnt;
          end else begin
            // Node read last cycle is on rdata now
            rd_wait <= 1'b0;
            res_dat <= rd_node[`NODE_DAT_HI:`NODE_DAT_LO];
            wr_addr <= rd_addr;
            if (!rd_node[`NODE_USED]) begin
              fnd_q   <= 1'b0;
              wr_node <= new_node;
              state   <= (op_q == ADD) ? WRITE : DONE;
            end else if (key_hit) begin
              // Overwrite keeps key and link, only data changes
              fnd_q   <= 1'b1;
              wr_node <= {rd_node[`NODE_USED:`NODE_KEY_LO], dat_q,
                          rd_node[`NODE_NXT_HI:`NODE_NXT_LO]};
              state   <= (op_q == ADD) ? WRITE : DONE;
            end else if (rd_node[`NODE_NXT_HI:`NODE_NXT_LO] != '0) begin
              cur_addr <= {1'b1, rd_node[`NODE_NXT_HI:`NODE_NXT_LO]};
              state    <= READ_CHAIN;
            end else if ((op_q == ADD) && !full_q) begin
              // Tail reached, new node goes to a fresh slot and the tail gets linked
              fnd_q     <= 1'b0;
              wr_addr   <= {1'b1, alloc_ptr};
              wr_node   <= new_node;
              link_addr <= rd_addr;
              link_node <= {rd_node[`NODE_USED:`NODE_DAT_LO], alloc_ptr};
              link_pend <= 1'b1;
              alloc_ptr <= alloc_ptr + 1'b1;
              if (alloc_ptr == chain_ptr_t'(`CHAIN_SLOTS)) begin
                full_q <= 1'b1;
              end
              state <= WRITE;
            end else begin
              fnd_q <= 1'b0;
              state <= DONE;
            end
          end
        end
        WRITE: begin
          if (mem.gnt) begin
            if (link_pend) begin
              wr_addr   <= link_addr;
              wr_node   <= link_node;
              link_pend <= 1'b0;
            end else begin
              state <= DONE;
            end
          end
        end
        DONE: begin
          rdy_q <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase

      // A running clear drops the request in flight and frees all chain slots
      if (i_clear_busy) begin
        state     <= IDLE;
        rdy_q     <= 1'b0;
        rd_wait   <= 1'b0;
        link_pend <= 1'b0;
        full_q    <= 1'b0;
        alloc_ptr <= chain_ptr_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* src/table_clearer.sv */
// Marks all bucket heads unused after reset or a clear request, busy until done
`timescale 1ns/1ps
`include "hash_map_macros.svh"
`default_nettype none

module table_clearer (
  input  logic          i_clk,
  input  logic          coll_ram_rst,
  input  logic          i_cfg_clr,
  output logic          o_busy,
  node_mem_if.requester mem
);
  import hash_map_pkg::*;

  logic    busy;
  logic    start;
  bucket_t cnt;

  // One idle start cycle, then one write per bucket
  assign mem.req   = busy && !start;
  assign mem.we    = 1'b1;
  assign mem.addr  = {1'b0, cnt};
  assign mem.wdata = '0;
  assign o_busy    = busy;

  always_ff @(posedge i_clk) begin
    if (!coll_ram_rst || i_cfg_clr) begin
      busy  <= 1'b1;
      start <= 1'b1;
      cnt   <= '0;
    end else if (start) begin
      start <= 1'b0;
    end else if (busy && mem.gnt) begin
      cnt <= cnt + 1'b1;
      if (cnt == bucket_t'(`NUM_BUCKETS - 1)) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/node_store.sv */
// Single node RAM shared by the clearer and the walker, clearer has fixed priority
`timescale 1ns/1ps
`include "hash_map_macros.svh"
`default_nettype none

module node_store (
  input  logic      i_clk,
  node_mem_if.store walk_mem,
  node_mem_if.store clear_mem
);
  import hash_map_pkg::*;

  node_t      ram [`NUM_NODES];
  node_t      rdata_q;
  logic       acc;
  logic       sel_we;
  node_addr_t sel_addr;
  node_t      sel_wdata;

  assign clear_mem.gnt = clear_mem.req;
  assign walk_mem.gnt  = walk_mem.req && !clear_mem.req;

  // Winner's access
  assign acc       = clear_mem.gnt || walk_mem.gnt;
  assign sel_we    = clear_mem.req ? clear_mem.we    : walk_mem.we;
  assign sel_addr  = clear_mem.req ? clear_mem.addr  : walk_mem.addr;
  assign sel_wdata = clear_mem.req ? clear_mem.wdata : walk_mem.wdata;

  always_ff @(posedge i_clk) begin
    if (acc) begin
      if (sel_we) begin
        ram[sel_addr] <= sel_wdata;
      end else begin
        rdata_q <= ram[sel_addr];
      end
    end
  end

  // Both requesters see the same read data
  assign walk_mem.rdata  = rdata_q;
  assign clear_mem.rdata = rdata_q;

endmodule

`default_nettype wire

/* src/hash_map.sv */
// Hash map top level with 32-bit keys and 8-bit data, connects hash, walker, clearer and store
`timescale 1ns/1ps
`default_nettype none

module hash_map (
  input  logic               i_clk,
  input  logic               coll_ram_rst,
  input  hash_map_pkg::key_t i_key,
  input  hash_map_pkg::dat_t i_dat,
  input  logic               i_val,
  input  logic               i_opcode,
  input  logic               i_cfg_clr,
  output logic               o_rdy,
  output hash_map_pkg::dat_t o_dat,
  output logic               o_val,
  output logic               o_fnd,
  output logic               o_cfg_full
);
  import hash_map_pkg::*;

  key_t    walk_key;
  bucket_t bucket;
  logic    clear_busy;

  node_mem_if walk_mem ();
  node_mem_if clear_mem ();

  crc_hash u_crc_hash (
    .i_key    (walk_key),
    .o_bucket (bucket)
  );

  bucket_walker u_bucket_walker (
    .i_clk        (i_clk),
    .coll_ram_rst (coll_ram_rst),
    .i_key        (i_key),
    .i_dat        (i_dat),
    .i_val        (i_val),
    .i_opcode     (i_opcode),
    .i_clear_busy (clear_busy),
    .i_bucket     (bucket),
    .o_key        (walk_key),
    .o_rdy        (o_rdy),
    .o_dat        (o_dat),
    .o_val        (o_val),
    .o_fnd        (o_fnd),
    .o_full       (o_cfg_full),
    .mem          (walk_mem)
  );

  table_clearer u_table_clearer (
    .i_clk        (i_clk),
    .coll_ram_rst (coll_ram_rst),
    .i_cfg_clr    (i_cfg_clr),
    .o_busy       (clear_busy),
    .mem          (clear_mem)
  );

  node_store u_node_store (
    .i_clk     (i_clk),
    .walk_mem  (walk_mem),
    .clear_mem (clear_mem)
  );

endmodule

`default_nettype wire

/* test/clk_gen.sv */
// Testbench clock with a 100 ns period and a low reset held for the first 3 cycles
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic o_clk,
  output logic o_coll_ram_rst
);

  initial begin
    o_clk          = 1'b0;
    o_coll_ram_rst = 1'b0;
    repeat (3) @(posedge o_clk);
    // Release away from the sampling edge
    @(negedge o_clk);
    o_coll_ram_rst = 1'b1;
  end

  always #50 o_clk = ~o_clk;

endmodule

`default_nettype wire

/* test/hash_map_assert.sv */
// Protocol assertions on the hash map ready and result outputs for binding into the hash_map top
`timescale 1ns/1ps
`default_nettype none

module hash_map_assert (
  input logic i_clk,
  input logic coll_ram_rst,
  input logic i_val,
  input logic i_rdy,
  input logic i_res_val,
  input logic i_busy
);

  // High from a taken request until its result or a clear
  logic req_open;

  always_ff @(posedge i_clk) begin
    if (!coll_ram_rst || i_busy) begin
      req_open <= 1'b0;
    end else if (i_rdy && i_val) begin
      req_open <= 1'b1;
    end else if (i_res_val) begin
      req_open <= 1'b0;
    end
  end

  // An aborted request gives no result later
  a_val_has_req: assert property (@(posedge i_clk) disable iff (!coll_ram_rst)
    i_res_val |-> req_open)
    else $error("o_val without an open request");

  // Result is a single-cycle pulse
  a_val_pulse: assert property (@(posedge i_clk) disable iff (!coll_ram_rst)
    i_res_val |=> !i_res_val)
    else $error("o_val held longer than one cycle");

  a_rdy_not_val: assert property (@(posedge i_clk) disable iff (!coll_ram_rst)
    !(i_rdy && i_res_val))
    else $error("o_rdy and o_val high together");

  // Ready stays low for one cycle after the clear ends
  a_busy_not_rdy: assert property (@(posedge i_clk) disable iff (!coll_ram_rst)
    i_busy |=> !i_rdy)
    else $error("o_rdy high during or right after the table clear");

endmodule

bind hash_map hash_map_assert u_hash_map_assert (
  .i_clk        (i_clk),
  .coll_ram_rst (coll_ram_rst),
  .i_val        (i_val),
  .i_rdy        (o_rdy),
  .i_res_val    (o_val),
  .i_busy       (clear_busy)
);

`default_nettype wire

/* test/tb_hash_map.sv */
// Testbench top for the hash map, random adds and lookups checked against a reference model
`timescale 1ns/1ps
`include "hash_map_macros.svh"
`default_nettype none

module tb_hash_map;
  import hash_map_pkg::*;

  logic i_clk;
  logic coll_ram_rst;
  key_t i_key;
  dat_t i_dat;
  logic i_val;
  logic i_opcode;
  logic i_cfg_clr;
  logic o_rdy;
  dat_t o_dat;
  logic o_val;
  logic o_fnd;
  logic o_cfg_full;

  logic [31:0] lfsr;
  dat_t        ref_map [key_t];
  logic [7:0]  bkt_used;
  int          n_alloc;
  int          n_check;
  int          n_err;
  int          n_timeout;
  logic        stalled;
  key_t        keys [$];

  clk_gen u_clk_gen (.o_clk(i_clk), .o_coll_ram_rst(coll_ram_rst));

  hash_map UUT (
    .i_clk (i_clk), .coll_ram_rst (coll_ram_rst), .i_key (i_key), .i_dat (i_dat),
    .i_val (i_val), .i_opcode (i_opcode), .i_cfg_clr (i_cfg_clr), .o_rdy (o_rdy),
    .o_dat (o_dat), .o_val (o_val), .o_fnd (o_fnd), .o_cfg_full (o_cfg_full)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // CRC-32 with zero seed, key MSB first, bucket from the low bits
  function automatic bucket_t model_bucket(input key_t k);
    logic [31:0] r;
    r = '0;
    for (int i = 31; i >= 0; i--) begin
      r = (r << 1) ^ (((r[31] ^ k[i]) == 1'b1) ? `CRC_POLY : 32'h0);
    end
    return r[2:0];
  endfunction

  function automatic logic will_refuse(input key_t k);
    return !ref_map.exists(k) && bkt_used[model_bucket(k)] && (n_alloc == `CHAIN_SLOTS);
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_check++;
    if (exp !== act) begin
      $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
      n_err++;
    end
  endtask

  task automatic run_op(input logic op, input key_t k, input dat_t d,
                        output logic fnd, output dat_t q, output logic full);
    int cnt;
    fnd = 1'b0;
    q = '0;
    full = 1'b0;
    if (stalled) return;
    cnt = 0;
    while (o_rdy !== 1'b1 && cnt < 200) begin
      @(negedge i_clk);
      cnt++;
    end
    if (o_rdy !== 1'b1) begin
      $display("Timeout: the map never became ready for a request");
      n_timeout++;
      stalled = 1'b1;
      return;
    end
    i_key    = k;
    i_dat    = d;
    i_opcode = op;
    i_val    = 1'b1;
    @(negedge i_clk);
    i_val = 1'b0;
    cnt = 0;
    while (o_val !== 1'b1 && cnt < 200) begin
      @(negedge i_clk);
      cnt++;
    end
    if (o_val !== 1'b1) begin
      $display("Timeout: no result pulse after a request was taken");
      n_timeout++;
      stalled = 1'b1;
      return;
    end
    fnd  = o_fnd;
    q    = o_dat;
    full = o_cfg_full;
  endtask

  task automatic add_check(input string name, input key_t k, input dat_t d);
    logic    fnd;
    logic    full;
    logic    exp_fnd;
    dat_t    q;
    bucket_t b;
    b       = model_bucket(k);
    exp_fnd = ref_map.exists(k) != 0;
    if (exp_fnd) begin
      ref_map[k] = d;
    end else if (!bkt_used[b]) begin
      bkt_used[b] = 1'b1;
      ref_map[k]  = d;
    end else if (n_alloc < `CHAIN_SLOTS) begin
      n_alloc++;
      ref_map[k] = d;
    end
    run_op(1'b1, k, d, fnd, q, full);
    check({name, " fnd"}, 32'(exp_fnd), 32'(fnd));
    check({name, " full"}, 32'(n_alloc == `CHAIN_SLOTS), 32'(full));
  endtask

  task automatic lookup_check(input string name, input key_t k);
    logic fnd;
    logic full;
    logic exp_fnd;
    dat_t q;
    exp_fnd = ref_map.exists(k) != 0;
    run_op(1'b0, k, '0, fnd, q, full);
    check({name, " fnd"}, 32'(exp_fnd), 32'(fnd));
    if (exp_fnd) check({name, " dat"}, 32'(ref_map[k]), 32'(q));
    check({name, " full"}, 32'(n_alloc == `CHAIN_SLOTS), 32'(full));
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] rd;
    int          n;
    i_key = '0;
    i_dat = '0;
    i_val = 1'b0;
    i_opcode = 1'b0;
    i_cfg_clr = 1'b0;
    lfsr = 32'hd3d7;
    bkt_used = '0;
    n_alloc = 0;
    n_check = 0;
    n_err = 0;
    n_timeout = 0;
    stalled = 1'b0;
    @(negedge i_clk);

    // Empty table after reset
    for (int i = 0; i < 10; i++) begin
      take_bits(32, r);
      lookup_check("t1 lookup", r);
    end

    for (int i = 0; i < 6; i++) begin
      take_bits(32, r);
      take_bits(8, rd);
      add_check("t2 add", r, rd[7:0]);
      keys.push_back(r);
    end
    foreach (keys[i]) lookup_check("t2 lookup", keys[i]);

    take_bits(8, rd);
    add_check("t3 overwrite", keys[0], rd[7:0]);
    lookup_check("t3 lookup", keys[0]);

    // Fill until a new key needs a chain slot and none is left
    n = 0;
    take_bits(32, r);
    while (!will_refuse(r) && n < 100) begin
      take_bits(8, rd);
      add_check("t4 add", r, rd[7:0]);
      keys.push_back(r);
      take_bits(32, r);
      n++;
    end
    if (!will_refuse(r)) begin
      $display("The table did not reach the full state within 100 adds");
      n_err++;
    end
    take_bits(8, rd);
    add_check("t4 refused add", r, rd[7:0]);
    lookup_check("t4 refused lookup", r);

    i_cfg_clr = 1'b1;
    @(negedge i_clk);
    i_cfg_clr = 1'b0;
    ref_map.delete();
    bkt_used = '0;
    n_alloc = 0;
    foreach (keys[i]) lookup_check("t5 old lookup", keys[i]);
    keys.delete();
    for (int i = 0; i < 5; i++) begin
      take_bits(32, r);
      take_bits(8, rd);
      add_check("t5 add", r, rd[7:0]);
      keys.push_back(r);
    end
    foreach (keys[i]) lookup_check("t5 lookup", keys[i]);

    $display("checks %0d, errors %0d, timeouts %0d", n_check, n_err, n_timeout);
    if (n_err == 0 && n_timeout == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hash_map.f */
+incdir+src
src/hash_map_pkg.sv
src/node_mem_if.sv
src/crc_hash.sv
src/bucket_walker.sv
src/table_clearer.sv
src/node_store.sv
src/hash_map.sv
test/clk_gen.sv
test/hash_map_assert.sv
test/tb_hash_map.sv

/* Makefile */
TOP = tb_hash_map

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f hash_map.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
